// File: design/doodlePkg.sv
/*
 * doodle scene shared definitions
 * screen limits, platform geometry, random lane setup and the
 * display colours used by the field and the colour pipeline
 */

package doodlePkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    // screen coordinate, wide enough for 640x480
    localparam int CoordW = 10;
    // platform position and random lane width
    localparam int PosW = 9;

    // ----------------------------------------
    // screen and platform geometry
    // ----------------------------------------
    localparam int ScreenYMax = 479;

    // platform box is centre +/- half size, edges inclusive
    localparam int PlatHalfW = 10;
    localparam int PlatHalfH = 4;

    // spacing of the reset ladder and the respawn row
    localparam int PlatLadderStep = 30;
    localparam int PlatBottomY = 475;

    // x shift applied to small random values
    localparam int PlatXLimit = 440;
    localparam int PlatXOffset = 100;

    // ----------------------------------------
    // random lanes
    // ----------------------------------------
    // lane i starts at LfsrSeedBase ^ i, never zero for up to 16 lanes
    localparam logic [PosW-1:0] LfsrSeedBase = 9'h1A5;
    // x^9 + x^5 + 1, feedback from bits 8 and 4
    localparam logic [PosW-1:0] LfsrTaps = 9'h110;

    // ----------------------------------------
    // colours, 8 bits each of red, green, blue
    // ----------------------------------------
    localparam logic [23:0] PlayerColour = 24'hCAC92E;
    localparam logic [23:0] PlatColour = 24'h66DD11;
    localparam logic [23:0] CannonColour = 24'hFF0000;
    localparam logic [23:0] BackColour = 24'h988558;

    // x position from a raw random value, result wraps to PosW bits
    function automatic logic [PosW-1:0] applyOffset(input logic [PosW-1:0] raw);
        int shifted;
        shifted = int'(raw);
        if (shifted < PlatXLimit)
        begin
            shifted = shifted + PlatXOffset;
        end
        return PosW'(shifted);
    endfunction

endpackage

// File: design/platformIf.sv
/*
 * platform position bus
 * carries the x and y tables of every platform from the field
 * registers to the colour pipeline
 */

`timescale 1ns/100ps

interface platformIf
    import doodlePkg::*;
#(
    parameter int NumPlats = 16
) ();

    // centre of each platform box
    logic [PosW-1:0] platX [NumPlats];
    logic [PosW-1:0] platY [NumPlats];

    // owner of the position registers
    modport field
    (
        output platX,
        output platY
    );

    // box tests in the pixel path
    modport mapper
    (
        input platX,
        input platY
    );

endinterface

// File: design/platformRng.sv
/*
 * platform random lanes
 * one 9-bit Fibonacci LFSR per platform, each with its own seed,
 * all stepping on every frame clock edge
 */

`timescale 1ns/100ps

module platformRng
    import doodlePkg::*;
#(
    parameter int NumPlats = 16
)
(
    input  logic            frame_clk,
    input  logic            loadplat,
    output logic [PosW-1:0] laneVal [NumPlats]
);

    // ----------------------------------------
    // lane registers
    // ----------------------------------------
    // lanes are independent, shift left and feed parity of the taps into bit 0
    always_ff @(posedge frame_clk or posedge loadplat)
    begin
        if (loadplat)
        begin
            for (int i = 0; i < NumPlats; i++)
            begin
                laneVal[i] <= LfsrSeedBase ^ PosW'(i);
            end
        end
        else
        begin
            for (int i = 0; i < NumPlats; i++)
            begin
                laneVal[i] <= {laneVal[i][PosW-2:0], ^(laneVal[i] & LfsrTaps)};
            end
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    // a lane that reaches zero stays there, so the respawn x would freeze
    for (genvar g = 0; g < NumPlats; g++)
    begin : gLaneCheck
        assert property (@(posedge frame_clk) disable iff (loadplat)
            laneVal[g] != '0)
        else
            $error("random lane %0d locked at zero", g);
    end

endmodule

// File: design/platformField.sv
/*
 * platform field
 * owns the platform x and y registers
 * loads the y ladder and the seeded x values on reset, scrolls the
 * field up on each command and respawns platforms that would leave
 * the top at the bottom row
 */

`timescale 1ns/100ps

module platformField
    import doodlePkg::*;
#(
    parameter int NumPlats = 16
)
(
    input  logic              frame_clk,
    input  logic              loadplat,
    input  logic [PosW-1:0]   laneVal [NumPlats],
    input  logic              scrollValid,
    input  logic [CoordW-1:0] scrollAmt,
    platformIf.field          plat
);

    logic [PosW-1:0] xPos [NumPlats];
    logic [PosW-1:0] yPos [NumPlats];

    // per platform stay-on flag and scrolled row
    logic            stayOn [NumPlats];
    logic [PosW-1:0] scrolledY [NumPlats];

    // reset row of platform idx with the last one clamped to the respawn row
    function automatic logic [PosW-1:0] ladderY(input int idx);
        int rowY;
        rowY = PlatLadderStep * (idx + 1);
        if ((idx == NumPlats - 1) && (rowY > PlatBottomY))
        begin
            rowY = PlatBottomY;
        end
        return PosW'(rowY);
    endfunction

    // ----------------------------------------
    // scroll decision
    // ----------------------------------------
    always_comb
    begin
        for (int i = 0; i < NumPlats; i++)
        begin
            // whole box must stay at or below row 0
            stayOn[i] = int'(yPos[i]) >= int'(scrollAmt) + PlatHalfH;
            scrolledY[i] = PosW'(int'(yPos[i]) - int'(scrollAmt));
        end
    end

    // ----------------------------------------
    // position registers
    // ----------------------------------------
    always_ff @(posedge frame_clk or posedge loadplat)
    begin
        if (loadplat)
        begin
            for (int i = 0; i < NumPlats; i++)
            begin
                // x follows the seed the lane starts from
                xPos[i] <= applyOffset(LfsrSeedBase ^ PosW'(i));
                yPos[i] <= ladderY(i);
            end
        end
        else if (scrollValid)
        begin
            for (int i = 0; i < NumPlats; i++)
            begin
                if (stayOn[i])
                begin
                    yPos[i] <= scrolledY[i];
                end
                else
                begin
                    // respawn at the bottom with the lane value before this edge
                    yPos[i] <= PosW'(PlatBottomY);
                    xPos[i] <= applyOffset(laneVal[i]);
                end
            end
        end
    end

    assign plat.platX = xPos;
    assign plat.platY = yPos;

    // ----------------------------------------
    // checks
    // ----------------------------------------
    // a scroll that wrapped past row 0 shows up as a row below the screen
    for (genvar g = 0; g < NumPlats; g++)
    begin : gRowCheck
        assert property (@(posedge frame_clk) disable iff (loadplat)
            int'(yPos[g]) <= ScreenYMax)
        else
            $error("platform %0d below the screen, y %0d", g, yPos[g]);
    end

endmodule

// File: design/pixelMapper.sv
/*
 * pixel colour pipeline
 * stage one tests a pixel query against the player, platform and
 * cannon boxes; stage two picks the colour by priority
 * player, platform, cannon, background
 * both stages use valid/ready and hold one query each
 */

`timescale 1ns/100ps

module pixelMapper
    import doodlePkg::*;
#(
    parameter int NumPlats = 16
)
(
    input  logic              frame_clk,
    input  logic              loadplat,
    platformIf.mapper         plat,

    input  logic [CoordW-1:0] playerX,
    input  logic [CoordW-1:0] playerY,
    input  logic [CoordW-1:0] playerSize,
    input  logic [CoordW-1:0] cannonX,
    input  logic [CoordW-1:0] cannonY,
    input  logic [CoordW-1:0] cannonSize,

    input  logic              pixValid,
    input  logic [CoordW-1:0] drawX,
    input  logic [CoordW-1:0] drawY,
    output logic              pixReady,

    output logic              colValid,
    output logic [7:0]        red,
    output logic [7:0]        green,
    output logic [7:0]        blue,
    input  logic              colReady
);

    // inclusive box test in signed integer space, no wrap at the edges
    function automatic logic boxHit(
        input logic [CoordW-1:0] px,
        input logic [CoordW-1:0] py,
        input logic [CoordW-1:0] cx,
        input logic [CoordW-1:0] cy,
        input logic [CoordW-1:0] hx,
        input logic [CoordW-1:0] hy
    );
        logic inX;
        logic inY;
        inX = (int'(px) >= int'(cx) - int'(hx)) && (int'(px) <= int'(cx) + int'(hx));
        inY = (int'(py) >= int'(cy) - int'(hy)) && (int'(py) <= int'(cy) + int'(hy));
        return inX && inY;
    endfunction

    // combinational hits for the query on the inputs
    logic playerHit;
    logic platHit;
    logic cannonHit;

    // stage one
    logic s1Valid;
    logic s1Player;
    logic s1Plat;
    logic s1Cannon;

    // stage two
    logic        s2Ready;
    logic [23:0] colourQ;

    // ----------------------------------------
    // handshake
    // ----------------------------------------
    // stage two frees when empty or draining, stage one when it can move on
    assign s2Ready = !colValid || colReady;
    assign pixReady = !s1Valid || s2Ready;

    // ----------------------------------------
    // box tests
    // ----------------------------------------
    always_comb
    begin
        playerHit = boxHit(drawX, drawY, playerX, playerY, playerSize, playerSize);
        cannonHit = boxHit(drawX, drawY, cannonX, cannonY, cannonSize, cannonSize);
        platHit = 1'b0;
        for (int i = 0; i < NumPlats; i++)
        begin
            if (boxHit(drawX, drawY, CoordW'(plat.platX[i]), CoordW'(plat.platY[i]),
                       CoordW'(PlatHalfW), CoordW'(PlatHalfH)))
            begin
                platHit = 1'b1;
            end
        end
    end

    // ----------------------------------------
    // stage one, hit flags
    // ----------------------------------------
    always_ff @(posedge frame_clk or posedge loadplat)
    begin
        if (loadplat)
        begin
            s1Valid <= 1'b0;
        end
        else if (pixReady)
        begin
            s1Valid <= pixValid;
        end
    end

    always_ff @(posedge frame_clk)
    begin
        if (pixValid && pixReady)
        begin
            s1Player <= playerHit;
            s1Plat <= platHit;
            s1Cannon <= cannonHit;
        end
    end

    // ----------------------------------------
    // stage two, colour by priority
    // ----------------------------------------
    always_ff @(posedge frame_clk or posedge loadplat)
    begin
        if (loadplat)
        begin
            colValid <= 1'b0;
        end
        else if (s2Ready)
        begin
            colValid <= s1Valid;
        end
    end

    always_ff @(posedge frame_clk)
    begin
        if (s1Valid && s2Ready)
        begin
            if (s1Player)
                colourQ <= PlayerColour;
            else if (s1Plat)
                colourQ <= PlatColour;
            else if (s1Cannon)
                colourQ <= CannonColour;
            else
                colourQ <= BackColour;
        end
    end

    assign red = colourQ[23:16];
    assign green = colourQ[15:8];
    assign blue = colourQ[7:0];

    // held colour must not move until the consumer takes it
    assert property (@(posedge frame_clk) disable iff (loadplat)
        colValid && !colReady |=> colValid && $stable({red, green, blue}))
    else
        $error("colour output changed while stalled");

endmodule

// File: design/doodleScene.sv
/*
 * doodle scene display core
 * random platform field with scrolling and respawn, plus the
 * two-stage colour pipeline for pixel queries
 */

`timescale 1ns/100ps

module doodleScene
    import doodlePkg::*;
#(
    parameter int NumPlats = 16
)
(
    input  logic              frame_clk,
    input  logic              loadplat,

    // scroll command, taken every cycle it is valid
    input  logic              scrollValid,
    input  logic [CoordW-1:0] scrollAmt,

    // player and cannon boxes
    input  logic [CoordW-1:0] playerX,
    input  logic [CoordW-1:0] playerY,
    input  logic [CoordW-1:0] playerSize,
    input  logic [CoordW-1:0] cannonX,
    input  logic [CoordW-1:0] cannonY,
    input  logic [CoordW-1:0] cannonSize,

    // pixel query
    input  logic              pixValid,
    input  logic [CoordW-1:0] drawX,
    input  logic [CoordW-1:0] drawY,
    output logic              pixReady,

    // colour result
    output logic              colValid,
    output logic [7:0]        red,
    output logic [7:0]        green,
    output logic [7:0]        blue,
    input  logic              colReady
);

    logic [PosW-1:0] laneVal [NumPlats];

    platformIf #(.NumPlats(NumPlats)) platBus ();

    // ----------------------------------------
    // platform field
    // ----------------------------------------
    platformRng #(.NumPlats(NumPlats)) rng0
    (
        .frame_clk (frame_clk),
        .loadplat  (loadplat),
        .laneVal   (laneVal)
    );

    platformField #(.NumPlats(NumPlats)) field0
    (
        .frame_clk   (frame_clk),
        .loadplat    (loadplat),
        .laneVal     (laneVal),
        .scrollValid (scrollValid),
        .scrollAmt   (scrollAmt),
        .plat        (platBus.field)
    );

    // ----------------------------------------
    // colour pipeline
    // ----------------------------------------
    pixelMapper #(.NumPlats(NumPlats)) mapper0
    (
        .frame_clk  (frame_clk),
        .loadplat   (loadplat),
        .plat       (platBus.mapper),
        .playerX    (playerX),
        .playerY    (playerY),
        .playerSize (playerSize),
        .cannonX    (cannonX),
        .cannonY    (cannonY),
        .cannonSize (cannonSize),
        .pixValid   (pixValid),
        .drawX      (drawX),
        .drawY      (drawY),
        .pixReady   (pixReady),
        .colValid   (colValid),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .colReady   (colReady)
    );

endmodule

// File: verification/sceneChecker.sv
/*
 * scene checker
 * models the random lanes and the platform table from the scene's
 * ports, predicts the colour of every accepted pixel query and
 * compares it with the colour the scene delivers
 */

`timescale 1ns/100ps

module sceneChecker
    import doodlePkg::*;
#(
    parameter int NumPlats = 16
)
(
    input  logic              frame_clk,
    input  logic              loadplat,
    input  logic              scrollValid,
    input  logic [CoordW-1:0] scrollAmt,
    input  logic [CoordW-1:0] playerX,
    input  logic [CoordW-1:0] playerY,
    input  logic [CoordW-1:0] playerSize,
    input  logic [CoordW-1:0] cannonX,
    input  logic [CoordW-1:0] cannonY,
    input  logic [CoordW-1:0] cannonSize,
    input  logic              pixValid,
    input  logic [CoordW-1:0] drawX,
    input  logic [CoordW-1:0] drawY,
    input  logic              pixReady,
    input  logic              colValid,
    input  logic [7:0]        red,
    input  logic [7:0]        green,
    input  logic [7:0]        blue,
    input  logic              colReady,
    output int                errCount,
    output int                checkCount,
    output int                pendCount,
    output int                respawnCount
);

    logic [PosW-1:0] laneM [NumPlats];
    logic [PosW-1:0] modelX [NumPlats];
    logic [PosW-1:0] modelY [NumPlats];

    // expected colours and their query coordinates, oldest first
    logic [23:0] expQ [$];
    logic [19:0] whereQ [$];

    // x^9 + x^5 + 1, new bit from bits 8 and 4
    function automatic logic [PosW-1:0] stepLane(input logic [PosW-1:0] v);
        return {v[7:0], v[8] ^ v[4]};
    endfunction

    // small values move right, the sum wraps to 9 bits
    function automatic logic [PosW-1:0] offsetX(input logic [PosW-1:0] raw);
        int v;
        v = raw;
        if (v < PlatXLimit)
        begin
            v = v + PlatXOffset;
        end
        return v % 512;
    endfunction

    function automatic int resetY(input int idx);
        int y;
        y = PlatLadderStep * (idx + 1);
        if (idx == NumPlats - 1 && y > PlatBottomY)
        begin
            y = PlatBottomY;
        end
        return y;
    endfunction

    function automatic bit inBox(input int px, input int py, input int cx, input int cy,
                                 input int hx, input int hy);
        return px >= cx - hx && px <= cx + hx && py >= cy - hy && py <= cy + hy;
    endfunction

    // colour by priority player, platform, cannon, background
    function automatic logic [23:0] expectColour(input int px, input int py);
        bit onPlat;
        onPlat = 0;
        for (int i = 0; i < NumPlats; i++)
        begin
            if (inBox(px, py, modelX[i], modelY[i], PlatHalfW, PlatHalfH))
                onPlat = 1;
        end
        if (inBox(px, py, playerX, playerY, playerSize, playerSize))
            return 24'hCAC92E;
        if (onPlat)
            return 24'h66DD11;
        if (inBox(px, py, cannonX, cannonY, cannonSize, cannonSize))
            return 24'hFF0000;
        return 24'h988558;
    endfunction

    initial
    begin
        errCount = 0;
        checkCount = 0;
        pendCount = 0;
        respawnCount = 0;
    end

    // ----------------------------------------
    // per-edge model and compare
    // ----------------------------------------
    always @(posedge frame_clk or posedge loadplat)
    begin : watchEdge
        logic [23:0] want;
        logic [19:0] where;
        if (loadplat)
        begin
            for (int i = 0; i < NumPlats; i++)
            begin
                laneM[i] = LfsrSeedBase ^ PosW'(i);
                modelX[i] = offsetX(LfsrSeedBase ^ PosW'(i));
                modelY[i] = PosW'(resetY(i));
            end
            expQ.delete();
            whereQ.delete();
        end
        else
        begin
            if (!pixReady && expQ.size() != 2)
            begin
                $display("** Error at %0t: pixReady low with %0d queries pending",
                         $time, expQ.size());
                errCount++;
            end
            if (colValid && colReady)
            begin
                if (expQ.size() == 0)
                begin
                    $display("colour delivered at %0t with no query pending", $time);
                    errCount++;
                end
                else
                begin
                    want = expQ.pop_front();
                    where = whereQ.pop_front();
                    checkCount++;
                    if ({red, green, blue} !== want)
                    begin
                        $display("** Error at %0t: query (%0d,%0d) gave %06h, expected %06h",
                                 $time, where[19:10], where[9:0], {red, green, blue}, want);
                        errCount++;
                    end
                end
            end
            // colour comes from the table as it is before this edge
            if (pixValid && pixReady)
            begin
                expQ.push_back(expectColour(drawX, drawY));
                whereQ.push_back({drawX, drawY});
            end
            if (scrollValid)
            begin
                for (int i = 0; i < NumPlats; i++)
                begin
                    if (int'(modelY[i]) >= int'(scrollAmt) + PlatHalfH)
                    begin
                        modelY[i] = PosW'(int'(modelY[i]) - int'(scrollAmt));
                    end
                    else
                    begin
                        modelY[i] = PosW'(PlatBottomY);
                        modelX[i] = offsetX(laneM[i]);
                        respawnCount++;
                    end
                end
            end
            for (int i = 0; i < NumPlats; i++)
            begin
                laneM[i] = stepLane(laneM[i]);
            end
        end
        pendCount = expQ.size();
    end

endmodule

// File: verification/tbDoodleScene.sv
/*
 * doodle scene testbench
 * drives reset, scroll commands and pixel queries, stalls the
 * colour output at random and leaves the comparing to the checker
 */

`timescale 1ns/100ps

module tbDoodleScene
    import doodlePkg::*;
();

    localparam int NumPlats = 16;
    localparam logic [31:0] Seed = 32'h0789c7d2;
    localparam int WaitLimit = 200;

    logic              frame_clk;
    logic              loadplat;
    logic              scrollValid;
    logic [CoordW-1:0] scrollAmt;
    logic [CoordW-1:0] playerX;
    logic [CoordW-1:0] playerY;
    logic [CoordW-1:0] playerSize;
    logic [CoordW-1:0] cannonX;
    logic [CoordW-1:0] cannonY;
    logic [CoordW-1:0] cannonSize;
    logic              pixValid;
    logic [CoordW-1:0] drawX;
    logic [CoordW-1:0] drawY;
    logic              pixReady;
    logic              colValid;
    logic [7:0]        red;
    logic [7:0]        green;
    logic [7:0]        blue;
    logic              colReady;

    int          checkerErrs;
    int          checkCount;
    int          pendCount;
    int          respawnCount;
    int          tbErrors;
    logic        timedOut;
    logic        stallOn;
    logic [31:0] rngState;
    logic [31:0] stallState;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial frame_clk = 1'b0;
    always #4 frame_clk = ~frame_clk;

    doodleScene #(.NumPlats(NumPlats)) dut0
    (
        .frame_clk(frame_clk), .loadplat(loadplat),
        .scrollValid(scrollValid), .scrollAmt(scrollAmt),
        .playerX(playerX), .playerY(playerY), .playerSize(playerSize),
        .cannonX(cannonX), .cannonY(cannonY), .cannonSize(cannonSize),
        .pixValid(pixValid), .drawX(drawX), .drawY(drawY), .pixReady(pixReady),
        .colValid(colValid), .red(red), .green(green), .blue(blue), .colReady(colReady)
    );

    sceneChecker #(.NumPlats(NumPlats)) checker0
    (
        .frame_clk(frame_clk), .loadplat(loadplat),
        .scrollValid(scrollValid), .scrollAmt(scrollAmt),
        .playerX(playerX), .playerY(playerY), .playerSize(playerSize),
        .cannonX(cannonX), .cannonY(cannonY), .cannonSize(cannonSize),
        .pixValid(pixValid), .drawX(drawX), .drawY(drawY), .pixReady(pixReady),
        .colValid(colValid), .red(red), .green(green), .blue(blue), .colReady(colReady),
        .errCount(checkerErrs), .checkCount(checkCount),
        .pendCount(pendCount), .respawnCount(respawnCount)
    );

    // random colour back-pressure on about half the cycles while enabled
    always @(posedge frame_clk)
    begin : stallDrive
        logic stallNow;
        stallNow = stallOn;
        #1;
        if (stallNow)
        begin
            stallState = lcgNext(stallState);
            colReady = stallState[31];
        end
        else
            colReady = 1'b1;
    end

    // ----------------------------------------
    // stimulus tasks entered 1 ns after an edge
    // ----------------------------------------
    task automatic sendQuery(input int x, input int y);
        int   waited;
        logic taken;
        if (timedOut)
            return;
        waited = 0;
        taken = 1'b0;
        pixValid = 1'b1;
        drawX = CoordW'(x);
        drawY = CoordW'(y);
        // pixReady is settled at the falling edge
        while (!taken && waited < WaitLimit)
        begin
            @(negedge frame_clk);
            taken = pixReady;
            @(posedge frame_clk);
            #1;
            waited++;
        end
        pixValid = 1'b0;
        if (!taken)
        begin
            $display("timeout: query at (%0d,%0d) was never accepted", x, y);
            timedOut = 1'b1;
        end
    endtask

    task automatic queryPlatform(input int idx, input int dx, input int dy);
        sendQuery(int'(checker0.modelX[idx]) + dx, int'(checker0.modelY[idx]) + dy);
    endtask

    task automatic sendScroll(input int amt);
        if (timedOut)
            return;
        scrollValid = 1'b1;
        scrollAmt = CoordW'(amt);
        @(posedge frame_clk);
        #1;
        scrollValid = 1'b0;
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while (pendCount != 0 && waited < WaitLimit)
        begin
            @(posedge frame_clk);
            #1;
            waited++;
        end
        if (pendCount != 0)
        begin
            $display("timeout: %0d colours never came out of the pipeline", pendCount);
            timedOut = 1'b1;
        end
    endtask

    initial
    begin
        loadplat = 1'b1;
        scrollValid = 1'b0;
        scrollAmt = '0;
        // player and cannon parked off screen
        playerX = 10'd1000;
        playerY = 10'd1000;
        playerSize = 10'd2;
        cannonX = 10'd900;
        cannonY = 10'd900;
        cannonSize = 10'd2;
        pixValid = 1'b0;
        drawX = '0;
        drawY = '0;
        colReady = 1'b1;
        stallOn = 1'b0;
        timedOut = 1'b0;
        tbErrors = 0;
        rngState = Seed;
        stallState = lcgNext(Seed);
        repeat (2) @(posedge frame_clk);
        #1;
        loadplat = 1'b0;

        // reset field at the centre and just outside each box
        for (int i = 0; i < NumPlats; i++)
        begin
            queryPlatform(i, 0, 0);
            queryPlatform(i, PlatHalfW + 1, 0);
            queryPlatform(i, 0, PlatHalfH + 1);
        end

        // player over platform 3, then cannon over platform 5
        playerX = CoordW'(checker0.modelX[3]);
        playerY = CoordW'(checker0.modelY[3]);
        playerSize = 10'd8;
        queryPlatform(3, 0, 0);
        queryPlatform(3, 0, PlatHalfH + 3);
        playerX = 10'd1000;
        playerY = 10'd1000;
        playerSize = 10'd2;
        cannonX = CoordW'(checker0.modelX[5]);
        cannonY = CoordW'(checker0.modelY[5]);
        cannonSize = 10'd8;
        queryPlatform(5, 0, 0);
        queryPlatform(5, 0, PlatHalfH + 3);
        cannonX = 10'd900;
        cannonY = 10'd900;
        cannonSize = 10'd2;

        // scrolling with respawns under random back-pressure
        stallOn = 1'b1;
        for (int r = 0; r < 30; r++)
        begin
            rngState = lcgNext(rngState);
            sendScroll(1 + int'(rngState[31:16] % 40));
            for (int i = 0; i < NumPlats; i++)
            begin
                queryPlatform(i, 0, 0);
            end
            rngState = lcgNext(rngState);
            sendQuery(int'(rngState[31:16] % 640), int'(rngState[15:0] % 480));
        end
        stallOn = 1'b0;
        waitDrain();

        if (!timedOut && respawnCount == 0)
        begin
            $display("no platform respawned during the scroll phase");
            tbErrors++;
        end
        $display("checks %0d, checker errors %0d, testbench errors %0d",
                 checkCount, checkerErrs, tbErrors);
        if (timedOut || checkerErrs != 0 || tbErrors != 0)
            $display("Test FAILED");
        else
            $display("Test OK");
        $finish;
    end

endmodule

// File: files.f
design/doodlePkg.sv
design/platformIf.sv
design/platformRng.sv
design/platformField.sv
design/pixelMapper.sv
design/doodleScene.sv
verification/sceneChecker.sv
verification/tbDoodleScene.sv

// File: Bender.yml
package:
  name: doodle_scene

sources:
  - design/doodlePkg.sv
  - design/platformIf.sv
  - design/platformRng.sv
  - design/platformField.sv
  - design/pixelMapper.sv
  - design/doodleScene.sv
  - target: test
    files:
      - verification/sceneChecker.sv
      - verification/tbDoodleScene.sv
